//--- verilog/mem_pkg.sv
//========================================
// Memory bridge package
// Widths, AXI codes, FSM states and the
// request, response and channel structs
//========================================

package mem_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int ID_W   = 4;

    // AXI size code for one 32-bit word per beat
    localparam logic [2:0] AXSIZE_WORD = 3'b010;
    // AXI prot for privileged secure data access
    localparam logic [2:0] PROT_PRIV   = 3'b001;

    // Performance counter widths
    localparam int PERF_W = 32;
    localparam int ERR_W  = 16;

    //========================================
    // Enums
    //========================================

    // Per-port transaction phases
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        ADDR = 2'b01,
        RESP = 2'b10,
        DONE = 2'b11
    } port_state_e;

    // AXI RRESP/BRESP codes where SLVERR and DECERR mark errors
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    //========================================
    // Structs
    //========================================

    // Core request of 69 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } mem_req_t;

    // Core response
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } mem_rsp_t;

    // Shared by AR and AW
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [2:0]        prot;
        logic [2:0]        size;
    } axi_ax_t;

    // Single-beat write data
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

endpackage

//--- verilog/axi_port_fsm.sv
//========================================
// Per-port AXI transaction FSM
// Steps one request through the address,
// response and core handoff phases
//========================================

`timescale 1ns/1ns

module axi_port_fsm import mem_pkg::*; #(
    // 0 for the read-only instruction port
    parameter bit WRITE_EN = 1'b1
) (
    input  logic clk_i,
    input  logic rst_ni,
    // Core side
    input  logic req_valid_i,
    input  logic req_write_i,
    output logic req_ready_o,
    output logic rsp_valid_o,
    input  logic rsp_ready_i,
    // AXI handshakes
    output logic ar_valid_o,
    input  logic ar_ready_i,
    output logic aw_valid_o,
    input  logic aw_ready_i,
    output logic w_valid_o,
    input  logic w_ready_i,
    input  logic r_valid_i,
    output logic r_ready_o,
    input  logic b_valid_i,
    output logic b_ready_o,
    // Strobes to the hold registers and monitor
    output logic load_o,
    output logic capture_o,
    output logic busy_o
);

    port_state_e state_q;
    port_state_e state_d;

    // AW and W can complete in either order
    logic aw_done_q;
    logic w_done_q;

    logic is_write;
    logic aw_fire;
    logic w_fire;
    logic addr_ok;
    logic rsp_fire;

    // Write flag comes from the held request, forced low on read-only ports
    assign is_write = WRITE_EN && req_write_i;

    //========================================
    // Handshake outputs
    //========================================

    assign req_ready_o = (state_q == IDLE);
    assign rsp_valid_o = (state_q == DONE);
    assign busy_o      = (state_q != IDLE);

    // Valids held steady from state and flags until ready is seen
    assign ar_valid_o = (state_q == ADDR) && !is_write;
    assign aw_valid_o = (state_q == ADDR) && is_write && !aw_done_q;
    assign w_valid_o  = (state_q == ADDR) && is_write && !w_done_q;

    assign r_ready_o  = (state_q == RESP) && !is_write;
    assign b_ready_o  = (state_q == RESP) && is_write;

    assign aw_fire = aw_valid_o && aw_ready_i;
    assign w_fire  = w_valid_o && w_ready_i;

    // Address phase complete for this cycle
    assign addr_ok = is_write ? ((aw_done_q || aw_fire) && (w_done_q || w_fire))
                              : ar_ready_i;

    // R or B beat taken
    assign rsp_fire = (r_ready_o && r_valid_i) || (b_ready_o && b_valid_i);

    assign load_o    = req_ready_o && req_valid_i;
    assign capture_o = rsp_fire;

    //========================================
    // Next state
    //========================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = ADDR;
                end
            end
            ADDR: begin
                if (addr_ok) begin
                    state_d = RESP;
                end
            end
            RESP: begin
                if (rsp_fire) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                // Core stall keeps the response on offer
                if (rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // Flags live only for one address phase
            if ((state_q == ADDR) && addr_ok) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                if (aw_fire) begin
                    aw_done_q <= 1'b1;
                end
                if (w_fire) begin
                    w_done_q <= 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/txn_hold_reg.sv
//========================================
// Per-port transaction hold registers
// Request, ID stamp and captured response
//========================================

`timescale 1ns/1ns

module txn_hold_reg import mem_pkg::*; #(
    parameter bit WRITE_EN = 1'b1
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              load_i,
    input  logic              capture_i,
    input  mem_req_t          req_i,
    input  logic [DATA_W-1:0] r_data_i,
    input  axi_resp_e         resp_i,
    output axi_ax_t           ax_o,
    output axi_w_t            w_o,
    output logic              write_o,
    output mem_rsp_t          rsp_o,
    output logic              err_pulse_o
);

    // Request and response payload
    mem_req_t req_q;
    mem_rsp_t rsp_q;

    // Control state
    logic            write_q;
    logic [ID_W-1:0] id_q;
    logic [ID_W-1:0] id_cnt_q;

    logic resp_err;

    assign resp_err    = (resp_i == SLVERR) || (resp_i == DECERR);
    // Error strobe for the monitor in the capture cycle
    assign err_pulse_o = capture_i && resp_err;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            write_q  <= 1'b0;
            id_q     <= '0;
            id_cnt_q <= '0;
        end else if (load_i) begin
            write_q  <= WRITE_EN && req_i.write;
            id_q     <= id_cnt_q;
            // Wraps at 2**ID_W
            id_cnt_q <= id_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            req_q <= req_i;
        end
        if (capture_i) begin
            // Writes return zero data
            rsp_q.rdata <= write_q ? '0 : r_data_i;
            rsp_q.err   <= resp_err;
        end
    end

    //========================================
    // Channel views of the held request
    //========================================

    assign ax_o.addr = req_q.addr;
    assign ax_o.id   = id_q;
    assign ax_o.prot = PROT_PRIV;
    assign ax_o.size = AXSIZE_WORD;

    assign w_o.data  = req_q.wdata;
    assign w_o.strb  = req_q.strb;

    assign write_o   = write_q;
    assign rsp_o     = rsp_q;

endmodule

//--- verilog/perf_monitor.sv
//========================================
// Bridge performance monitor
// Saturating counts of transactions,
// completions, errors and busy cycles
//========================================

`timescale 1ns/1ns

module perf_monitor import mem_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              i_accept_i,
    input  logic              d_accept_i,
    input  logic              i_done_i,
    input  logic              d_done_i,
    input  logic              i_err_i,
    input  logic              d_err_i,
    input  logic              i_busy_i,
    input  logic              d_busy_i,
    output logic [PERF_W-1:0] txn_count_o,
    output logic [PERF_W-1:0] done_count_o,
    output logic [ERR_W-1:0]  err_count_o,
    output logic [PERF_W-1:0] busy_cycles_o
);

    logic [PERF_W-1:0] txn_q;
    logic [PERF_W-1:0] done_q;
    logic [ERR_W-1:0]  err_q;
    logic [PERF_W-1:0] busy_q;

    // Per-cycle increments of 0 to 2
    logic [1:0] txn_inc;
    logic [1:0] done_inc;
    logic [1:0] err_inc;

    // One extra bit catches overflow
    logic [PERF_W:0] txn_sum;
    logic [PERF_W:0] done_sum;
    logic [ERR_W:0]  err_sum;

    assign txn_inc  = {1'b0, i_accept_i} + {1'b0, d_accept_i};
    assign done_inc = {1'b0, i_done_i} + {1'b0, d_done_i};
    assign err_inc  = {1'b0, i_err_i} + {1'b0, d_err_i};

    assign txn_sum  = {1'b0, txn_q} + {{(PERF_W-1){1'b0}}, txn_inc};
    assign done_sum = {1'b0, done_q} + {{(PERF_W-1){1'b0}}, done_inc};
    assign err_sum  = {1'b0, err_q} + {{(ERR_W-1){1'b0}}, err_inc};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            txn_q  <= '0;
            done_q <= '0;
            err_q  <= '0;
            busy_q <= '0;
        end else begin
            // Clamp at all ones on overflow
            txn_q  <= txn_sum[PERF_W] ? '1 : txn_sum[PERF_W-1:0];
            done_q <= done_sum[PERF_W] ? '1 : done_sum[PERF_W-1:0];
            err_q  <= err_sum[ERR_W] ? '1 : err_sum[ERR_W-1:0];
            // Overlapping busy ports count once
            if ((i_busy_i || d_busy_i) && !(&busy_q)) begin
                busy_q <= busy_q + 1'b1;
            end
        end
    end

    assign txn_count_o   = txn_q;
    assign done_count_o  = done_q;
    assign err_count_o   = err_q;
    assign busy_cycles_o = busy_q;

endmodule

//--- verilog/mem_bridge_top.sv
//========================================
// Memory bridge top level
// Instruction and data ports to AXI
//========================================

`timescale 1ns/1ns

module mem_bridge_top import mem_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    // Instruction core port
    input  logic              i_req_valid_i,
    input  logic [ADDR_W-1:0] i_req_addr_i,
    output logic              i_req_ready_o,
    output logic              i_rsp_valid_o,
    output mem_rsp_t          i_rsp_o,
    input  logic              i_rsp_ready_i,
    // Data core port
    input  logic              d_req_valid_i,
    input  mem_req_t          d_req_i,
    output logic              d_req_ready_o,
    output logic              d_rsp_valid_o,
    output mem_rsp_t          d_rsp_o,
    input  logic              d_rsp_ready_i,
    // Instruction AXI
    output logic              i_ar_valid_o,
    output axi_ax_t           i_ar_o,
    input  logic              i_ar_ready_i,
    input  logic              i_r_valid_i,
    input  logic [DATA_W-1:0] i_r_data_i,
    input  axi_resp_e         i_r_resp_i,
    output logic              i_r_ready_o,
    // Data AXI
    output logic              d_ar_valid_o,
    output axi_ax_t           d_ar_o,
    input  logic              d_ar_ready_i,
    output logic              d_aw_valid_o,
    output axi_ax_t           d_aw_o,
    input  logic              d_aw_ready_i,
    output logic              d_w_valid_o,
    output axi_w_t            d_w_o,
    input  logic              d_w_ready_i,
    input  logic              d_r_valid_i,
    input  logic [DATA_W-1:0] d_r_data_i,
    input  axi_resp_e         d_r_resp_i,
    output logic              d_r_ready_o,
    input  logic              d_b_valid_i,
    input  axi_resp_e         d_b_resp_i,
    output logic              d_b_ready_o,
    // Performance counters
    output logic [PERF_W-1:0] txn_count_o,
    output logic [PERF_W-1:0] done_count_o,
    output logic [ERR_W-1:0]  err_count_o,
    output logic [PERF_W-1:0] busy_cycles_o
);

    //========================================
    // Internal wires
    //========================================

    mem_req_t  i_req;
    axi_ax_t   d_ax;
    axi_resp_e d_resp;

    logic i_load;
    logic i_capture;
    logic i_busy;
    logic i_write;
    logic i_err;
    logic d_load;
    logic d_capture;
    logic d_busy;
    logic d_write;
    logic d_err;
    logic i_done;
    logic d_done;

    // Instruction fetch is a full-word read
    assign i_req.addr  = i_req_addr_i;
    assign i_req.write = 1'b0;
    assign i_req.wdata = '0;
    assign i_req.strb  = '1;

    // Same address struct drives AR and AW
    assign d_ar_o = d_ax;
    assign d_aw_o = d_ax;

    // B code for writes, R code for reads
    assign d_resp = axi_resp_e'(d_write ? d_b_resp_i : d_r_resp_i);

    // Completion is the core response handshake
    assign i_done = i_rsp_valid_o && i_rsp_ready_i;
    assign d_done = d_rsp_valid_o && d_rsp_ready_i;

    //========================================
    // Instruction port
    //========================================

    axi_port_fsm #(.WRITE_EN(1'b0)) u_i_fsm (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (i_req_valid_i),
        .req_write_i (i_write),
        .req_ready_o (i_req_ready_o),
        .rsp_valid_o (i_rsp_valid_o),
        .rsp_ready_i (i_rsp_ready_i),
        .ar_valid_o  (i_ar_valid_o),
        .ar_ready_i  (i_ar_ready_i),
        .aw_valid_o  (),
        .aw_ready_i  (1'b0),
        .w_valid_o   (),
        .w_ready_i   (1'b0),
        .r_valid_i   (i_r_valid_i),
        .r_ready_o   (i_r_ready_o),
        .b_valid_i   (1'b0),
        .b_ready_o   (),
        .load_o      (i_load),
        .capture_o   (i_capture),
        .busy_o      (i_busy)
    );

    txn_hold_reg #(.WRITE_EN(1'b0)) u_i_hold (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_i      (i_load),
        .capture_i   (i_capture),
        .req_i       (i_req),
        .r_data_i    (i_r_data_i),
        .resp_i      (i_r_resp_i),
        .ax_o        (i_ar_o),
        .w_o         (),
        .write_o     (i_write),
        .rsp_o       (i_rsp_o),
        .err_pulse_o (i_err)
    );

    //========================================
    // Data port
    //========================================

    axi_port_fsm #(.WRITE_EN(1'b1)) u_d_fsm (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (d_req_valid_i),
        .req_write_i (d_write),
        .req_ready_o (d_req_ready_o),
        .rsp_valid_o (d_rsp_valid_o),
        .rsp_ready_i (d_rsp_ready_i),
        .ar_valid_o  (d_ar_valid_o),
        .ar_ready_i  (d_ar_ready_i),
        .aw_valid_o  (d_aw_valid_o),
        .aw_ready_i  (d_aw_ready_i),
        .w_valid_o   (d_w_valid_o),
        .w_ready_i   (d_w_ready_i),
        .r_valid_i   (d_r_valid_i),
        .r_ready_o   (d_r_ready_o),
        .b_valid_i   (d_b_valid_i),
        .b_ready_o   (d_b_ready_o),
        .load_o      (d_load),
        .capture_o   (d_capture),
        .busy_o      (d_busy)
    );

    txn_hold_reg #(.WRITE_EN(1'b1)) u_d_hold (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_i      (d_load),
        .capture_i   (d_capture),
        .req_i       (d_req_i),
        .r_data_i    (d_r_data_i),
        .resp_i      (d_resp),
        .ax_o        (d_ax),
        .w_o         (d_w_o),
        .write_o     (d_write),
        .rsp_o       (d_rsp_o),
        .err_pulse_o (d_err)
    );

    //========================================
    // Monitor
    //========================================

    perf_monitor u_perf (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .i_accept_i    (i_load),
        .d_accept_i    (d_load),
        .i_done_i      (i_done),
        .d_done_i      (d_done),
        .i_err_i       (i_err),
        .d_err_i       (d_err),
        .i_busy_i      (i_busy),
        .d_busy_i      (d_busy),
        .txn_count_o   (txn_count_o),
        .done_count_o  (done_count_o),
        .err_count_o   (err_count_o),
        .busy_cycles_o (busy_cycles_o)
    );

endmodule

//--- tests/mem_bridge_assert.sv
//========================================
// Protocol assertions for one port FSM
//========================================

`timescale 1ns/1ns

module mem_bridge_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic req_ready_i,
    input logic rsp_valid_i,
    input logic rsp_ready_i,
    input logic ar_valid_i,
    input logic ar_ready_i,
    input logic aw_valid_i,
    input logic aw_ready_i,
    input logic w_valid_i,
    input logic w_ready_i
);

    // AXI valids hold until their ready
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i && !ar_ready_i |=> ar_valid_i)
        else $error("AR valid dropped before ready");
    aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_valid_i && !aw_ready_i |=> aw_valid_i)
        else $error("AW valid dropped before ready");
    w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_valid_i && !w_ready_i |=> w_valid_i)
        else $error("W valid dropped before ready");

    // Core response stays on offer
    rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i)
        else $error("Response valid dropped before ready");

    idle_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(req_ready_i && rsp_valid_i))
        else $error("req_ready and rsp_valid high together");

    // Quiet bus while in reset
    rst_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !ar_valid_i && !aw_valid_i && !w_valid_i)
        else $error("AXI valid high during reset");

endmodule

//--- tests/mem_bridge_tb.sv
//========================================
// Memory bridge testbench
// Vector replay with AXI slave models
//========================================

`timescale 1ns/1ns

module mem_bridge_tb import mem_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    // Samples land 90 ns after the edge
    localparam int SAMPLE_DLY = 80;
    localparam int WATCH_CYC  = 40;
    localparam int MAX_VEC    = 32;

    logic clk;
    logic rst_n;

    // Index 0 instruction port, index 1 data port
    logic      req_valid [2];
    mem_req_t  req       [2];
    logic      req_ready [2];
    logic      rsp_valid [2];
    mem_rsp_t  rsp       [2];
    logic      rsp_ready [2];
    logic      ar_valid  [2];
    axi_ax_t   ar        [2];
    logic      ar_ready  [2];
    logic      r_valid   [2];
    logic [31:0] r_data  [2];
    axi_resp_e r_resp    [2];
    logic      r_ready   [2];

    // Data-port write channels
    logic      aw_valid;
    axi_ax_t   aw;
    logic      aw_ready;
    logic      w_valid;
    axi_w_t    w;
    logic      w_ready;
    logic      b_valid;
    axi_resp_e b_resp;
    logic      b_ready;

    logic [PERF_W-1:0] txn_count;
    logic [PERF_W-1:0] done_count;
    logic [ERR_W-1:0]  err_count;
    logic [PERF_W-1:0] busy_cycles;

    // Vector fields in order of port, write, addr, wdata, strb, resp and rdata
    logic [111:0] vec_mem [MAX_VEC];
    int n_vec;
    int n_err_vec;
    int errors;
    int checks;
    int txn_idx [2];
    int unsigned rng_state;

    mem_bridge_top dut (
        .clk_i(clk), .rst_ni(rst_n),
        .i_req_valid_i(req_valid[0]), .i_req_addr_i(req[0].addr),
        .i_req_ready_o(req_ready[0]), .i_rsp_valid_o(rsp_valid[0]),
        .i_rsp_o(rsp[0]), .i_rsp_ready_i(rsp_ready[0]),
        .d_req_valid_i(req_valid[1]), .d_req_i(req[1]),
        .d_req_ready_o(req_ready[1]), .d_rsp_valid_o(rsp_valid[1]),
        .d_rsp_o(rsp[1]), .d_rsp_ready_i(rsp_ready[1]),
        .i_ar_valid_o(ar_valid[0]), .i_ar_o(ar[0]), .i_ar_ready_i(ar_ready[0]),
        .i_r_valid_i(r_valid[0]), .i_r_data_i(r_data[0]), .i_r_resp_i(r_resp[0]),
        .i_r_ready_o(r_ready[0]),
        .d_ar_valid_o(ar_valid[1]), .d_ar_o(ar[1]), .d_ar_ready_i(ar_ready[1]),
        .d_aw_valid_o(aw_valid), .d_aw_o(aw), .d_aw_ready_i(aw_ready),
        .d_w_valid_o(w_valid), .d_w_o(w), .d_w_ready_i(w_ready),
        .d_r_valid_i(r_valid[1]), .d_r_data_i(r_data[1]), .d_r_resp_i(r_resp[1]),
        .d_r_ready_o(r_ready[1]),
        .d_b_valid_i(b_valid), .d_b_resp_i(b_resp), .d_b_ready_o(b_ready),
        .txn_count_o(txn_count), .done_count_o(done_count),
        .err_count_o(err_count), .busy_cycles_o(busy_cycles)
    );

    bind axi_port_fsm mem_bridge_assert u_assert (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .req_ready_i(req_ready_o), .rsp_valid_i(rsp_valid_o),
        .rsp_ready_i(rsp_ready_i),
        .ar_valid_i(ar_valid_o), .ar_ready_i(ar_ready_i),
        .aw_valid_i(aw_valid_o), .aw_ready_i(aw_ready_i),
        .w_valid_i(w_valid_o), .w_ready_i(w_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // xorshift32 giving stall lengths of 0 to 3 cycles
    function automatic int next_delay();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return int'(rng_state % 4);
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    //========================================
    // One transaction on one port
    //========================================

    task automatic run_txn(input int p, input int k);
        logic [111:0] v;
        logic         wr;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        logic [31:0]  rdata;
        logic [3:0]   strb;
        logic [3:0]   exp_id;
        axi_resp_e    resp;
        string        pfx;
        int d_ar;
        int d_aw;
        int d_w;
        int d_r;
        int d_c;
        int c;
        bit ar_seen;
        bit aw_seen;
        bit w_seen;
        bit done;
        v      = vec_mem[k];
        wr     = v[104] && (p == 1);
        addr   = v[103:72];
        wdata  = v[71:40];
        strb   = v[39:36];
        resp   = axi_resp_e'(v[33:32]);
        rdata  = v[31:0];
        exp_id = 4'(txn_idx[p] % 16);
        txn_idx[p]++;
        pfx    = (p == 1) ? "d_" : "i_";

        // Request accepted at the coming edge
        req_valid[p] = 1'b1;
        req[p] = '{addr: addr, write: wr, wdata: wdata, strb: strb};
        #SAMPLE_DLY;
        check_val({pfx, "req_ready_o"}, 64'(req_ready[p]), 64'(1));
        next_cycle();
        req_valid[p] = 1'b0;

        // Address phase with independent ready stalls
        d_ar = next_delay();
        d_aw = next_delay();
        d_w  = next_delay();
        c = 0;
        ar_seen = 1'b0;
        aw_seen = 1'b0;
        w_seen = 1'b0;
        done = 1'b0;
        while (!done) begin
            ar_ready[p] = !wr && (c >= d_ar);
            if (p == 1) begin
                aw_ready = wr && (c >= d_aw) && !aw_seen;
                w_ready  = wr && (c >= d_w) && !w_seen;
            end
            #SAMPLE_DLY;
            check_val({pfx, "req_ready_o"}, 64'(req_ready[p]), 64'(0));
            if (!wr) begin
                check_val({pfx, "ar_valid_o"}, 64'(ar_valid[p]), 64'(1));
                if (ar_ready[p] && ar_valid[p]) begin
                    check_val({pfx, "ar_o.addr"}, 64'(ar[p].addr), 64'(addr));
                    check_val({pfx, "ar_o.id"}, 64'(ar[p].id), 64'(exp_id));
                    check_val({pfx, "ar_o.size"}, 64'(ar[p].size), 64'(AXSIZE_WORD));
                    check_val({pfx, "ar_o.prot"}, 64'(ar[p].prot), 64'(PROT_PRIV));
                    ar_seen = 1'b1;
                end
            end else begin
                check_val("d_aw_valid_o", 64'(aw_valid), 64'(!aw_seen));
                check_val("d_w_valid_o", 64'(w_valid), 64'(!w_seen));
                if (aw_ready && aw_valid) begin
                    check_val("d_aw_o.addr", 64'(aw.addr), 64'(addr));
                    check_val("d_aw_o.id", 64'(aw.id), 64'(exp_id));
                    check_val("d_aw_o.size", 64'(aw.size), 64'(AXSIZE_WORD));
                    check_val("d_aw_o.prot", 64'(aw.prot), 64'(PROT_PRIV));
                    aw_seen = 1'b1;
                end
                if (w_ready && w_valid) begin
                    check_val("d_w_o.data", 64'(w.data), 64'(wdata));
                    check_val("d_w_o.strb", 64'(w.strb), 64'(strb));
                    w_seen = 1'b1;
                end
            end
            done = wr ? (aw_seen && w_seen) : ar_seen;
            c++;
            next_cycle();
        end
        ar_ready[p] = 1'b0;
        if (p == 1) begin
            aw_ready = 1'b0;
            w_ready  = 1'b0;
        end

        // Slave answers after a random delay
        d_r = next_delay();
        c = 0;
        done = 1'b0;
        while (!done) begin
            if (c >= d_r) begin
                if (wr) begin
                    b_valid = 1'b1;
                    b_resp  = resp;
                end else begin
                    r_valid[p] = 1'b1;
                    r_data[p]  = rdata;
                    r_resp[p]  = resp;
                end
                done = 1'b1;
            end
            #SAMPLE_DLY;
            check_val({pfx, "req_ready_o"}, 64'(req_ready[p]), 64'(0));
            if (wr) begin
                check_val("d_b_ready_o", 64'(b_ready), 64'(1));
            end else begin
                check_val({pfx, "r_ready_o"}, 64'(r_ready[p]), 64'(1));
            end
            c++;
            next_cycle();
        end
        r_valid[p] = 1'b0;
        if (p == 1) begin
            b_valid = 1'b0;
        end

        // Core response under back-pressure
        d_c = next_delay();
        c = 0;
        done = 1'b0;
        while (!done) begin
            rsp_ready[p] = (c >= d_c);
            #SAMPLE_DLY;
            check_val({pfx, "rsp_valid_o"}, 64'(rsp_valid[p]), 64'(1));
            check_val({pfx, "req_ready_o"}, 64'(req_ready[p]), 64'(0));
            if (rsp_ready[p]) begin
                check_val({pfx, "rsp_o.rdata"}, 64'(rsp[p].rdata), 64'(wr ? 32'h0 : rdata));
                // Codes 2 and 3 are the error responses
                check_val({pfx, "rsp_o.err"}, 64'(rsp[p].err),
                          64'(v[33:32] >= 2'd2));
                done = 1'b1;
            end
            c++;
            next_cycle();
        end
        rsp_ready[p] = 1'b0;
    endtask

    task automatic run_port(input int p);
        for (int k = 0; k < n_vec; k++) begin
            if (int'(vec_mem[k][111:108]) == p) begin
                run_txn(p, k);
            end
        end
    endtask

    //========================================
    // Main sequence
    //========================================

    initial begin
        rst_n = 1'b0;
        rng_state = 77;
        errors = 0;
        checks = 0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        b_resp = OKAY;
        for (int p = 0; p < 2; p++) begin
            req_valid[p] = 1'b0;
            req[p] = '0;
            rsp_ready[p] = 1'b0;
            ar_ready[p] = 1'b0;
            r_valid[p] = 1'b0;
            r_data[p] = '0;
            r_resp[p] = OKAY;
            txn_idx[p] = 0;
        end
        // All ones marks an unused slot
        for (int k = 0; k < MAX_VEC; k++) begin
            vec_mem[k] = '1;
        end
        $readmemh("tests/mem_bridge_vectors.txt", vec_mem);
        n_vec = 0;
        n_err_vec = 0;
        while (n_vec < MAX_VEC && vec_mem[n_vec] !== '1) begin
            if (vec_mem[n_vec][33:32] >= 2'd2) begin
                n_err_vec++;
            end
            n_vec++;
        end

        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        next_cycle();

        fork
            run_port(0);
            run_port(1);
        join

        // Counters lag their events by a cycle
        repeat (3) next_cycle();
        check_val("txn_count_o", 64'(txn_count), 64'(n_vec));
        check_val("done_count_o", 64'(done_count), 64'(n_vec));
        check_val("err_count_o", 64'(err_count), 64'(n_err_vec));
        checks++;
        if (busy_cycles < 32'(3 * n_vec / 2)) begin
            errors++;
            $display("[ERROR] busy_cycles_o 0x%0h below minimum 0x%0h",
                     busy_cycles, 3 * n_vec / 2);
        end

        $display("Vectors: %0d, checks: %0d, errors: %0d", n_vec, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        #1;
        #(n_vec * WATCH_CYC * CLK_PERIOD);
        $display("Watchdog expired before all transactions completed");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- mem_bridge_top.f
verilog/mem_pkg.sv
verilog/axi_port_fsm.sv
verilog/txn_hold_reg.sv
verilog/perf_monitor.sv
verilog/mem_bridge_top.sv
tests/mem_bridge_assert.sv
tests/mem_bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f mem_bridge_top.f \
    --top-module mem_bridge_tb \
    -o mem_bridge_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- tests/mem_bridge_vectors.txt
// port_write_addr_wdata_strb_resp_rdata, all hex
// port 0 instruction, 1 data; resp 0 OKAY 1 EXOKAY 2 SLVERR 3 DECERR
0_0_00001000_00000000_f_0_13000093
0_0_00001004_00000000_f_1_00a00113
0_0_00001008_00000000_f_0_002081b3
0_0_0000100c_00000000_f_0_40110233
0_0_00001010_00000000_f_0_0000006f
0_0_00001014_00000000_f_1_fe5ff06f
0_0_00001018_00000000_f_0_00008067
0_0_0000101c_00000000_f_0_00100073
1_1_20000000_cafef00d_f_0_00000000
1_0_20000000_00000000_f_0_cafef00d
1_1_20000004_0000beef_3_2_00000000
1_0_20000008_00000000_f_3_12345678
1_1_2000000c_a5a5a5a5_c_1_00000000
1_0_20000010_00000000_f_0_87654321
1_1_20000014_11223344_1_3_00000000
1_0_20000018_00000000_f_2_deadbeef
